// ==== flash_rd_top.f ====
hdl/flash_rd_pkg.sv
hdl/flash_rd_buf_if.sv
hdl/flash_rd_order_if.sv
hdl/flash_rd_issue.sv
hdl/flash_rd_buffers.sv
hdl/flash_rd_rsp.sv
hdl/flash_rd_top.sv
test/flash_rd_props.sv
test/flash_rd_tb.sv

// ==== Makefile ====
# Verilator build and run of the flash read pipeline testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= flash_rd_tb
FILELIST  ?= flash_rd_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/flash_rd_testdata.txt ====
# R addr data [flash]: read a word, flash is 1 when the read must go to the flash
# P addr data: program a word while idle, E en: set the buffer enable
E 1
R 0010 ffef0010 1
R 0010 ffef0010 0
R 0011 ffee0011 1
R 0010 ffef0010 0
R 0011 ffee0011 0
P 0010 cafe0010
R 0010 cafe0010 1
R 0010 cafe0010 0
E 0
R 0010 cafe0010 1
R 0010 cafe0010 1
R 1234 edcb1234 1
E 1
R 0100 feff0100 1
R 0200 fdff0200 1
R 0100 feff0100 0
R 0300 fcff0300 1
R 0400 fbff0400 1
R 0500 faff0500 1
R 0200 fdff0200
R 0600 f9ff0600 1
R 0500 faff0500
R 0011 ffee0011 1

// ==== test/flash_rd_tb.sv ====
// testbench for the flash read pipeline with a flash model and file-driven reads
`default_nettype none

module flash_rd_tb
  import flash_rd_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HandshakeLimit = 200;
  localparam int IdleLimit      = 400;

  logic       clk_i;
  logic       rst_ni;
  logic       buf_en_i;
  logic       req_i;
  logic       prog_i;
  addr_t      addr_i;
  logic       rdy_o;
  logic       data_valid_o;
  data_t      data_o;
  logic       idle_o;
  logic       flash_req_o;
  addr_t      flash_addr_o;
  logic       flash_ack_i;
  logic       flash_done_i;
  data_t      flash_data_i;

  // flash contents and the expected responses in acceptance order
  data_t      mem [2**AddrW];
  data_t      exp_mem [256];
  logic [7:0] wr_idx;
  logic [7:0] rd_idx;
  int         data_errs;
  int         resp_errs;
  int         flag_errs;
  int         other_errs;

  flash_rd_top #(
    .NumBuf   (4),
    .RspDepth (4)
  ) i_flash_rd_top (
    .clk_i,
    .rst_ni,
    .buf_en_i,
    .req_i,
    .prog_i,
    .addr_i,
    .rdy_o,
    .data_valid_o,
    .data_o,
    .idle_o,
    .flash_req_o,
    .flash_addr_o,
    .flash_ack_i,
    .flash_done_i,
    .flash_data_i
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errs++;
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // flash model
  ////////////////////////////////////////////////////////////

  // one read at a time, ack after 0 to 2 cycles and done 1 to 4 cycles later
  initial begin
    addr_t pend_addr;
    int    ack_wait;
    int    done_wait;
    void'($urandom(32'h1dca_c173));
    flash_ack_i  = 1'b0;
    flash_done_i = 1'b0;
    flash_data_i = '0;
    pend_addr    = '0;
    ack_wait     = int'($urandom % 3);
    done_wait    = 0;
    forever begin
      @(posedge clk_i);
      flash_done_i <= 1'b0;
      if (done_wait != 0) begin
        done_wait = done_wait - 1;
        if (done_wait == 0) begin
          flash_done_i <= 1'b1;
          flash_data_i <= mem[pend_addr];
        end
      end
      // request and ack both high means the pipeline took the read at this edge
      if (flash_req_o && flash_ack_i) begin
        flash_ack_i <= 1'b0;
        pend_addr = flash_addr_o;
        done_wait = 1 + int'($urandom % 4);
        ack_wait  = int'($urandom % 3);
      end else if (flash_req_o) begin
        if (ack_wait == 0) begin
          flash_ack_i <= 1'b1;
        end else begin
          ack_wait = ack_wait - 1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response checker
  ////////////////////////////////////////////////////////////

  // sampled mid-cycle, after every acceptance of the previous edge is recorded
  initial begin
    rd_idx    = '0;
    data_errs = 0;
    resp_errs = 0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && data_valid_o) begin
        if (rd_idx == wr_idx) begin
          resp_errs++;
          $display("a response arrived while no read was outstanding");
        end else begin
          check_data("data_o", data_o, exp_mem[rd_idx]);
          rd_idx = rd_idx + 8'd1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  // holds req_i until the handshake and leaves it high for a back-to-back read
  task automatic issue_read(input addr_t a, input data_t exp, input bit chk,
                            input logic exp_req, output bit ok);
    logic saw_req;
    saw_req = 1'b0;
    ok      = 1'b0;
    req_i  <= 1'b1;
    addr_i <= a;
    for (int n = 0; n < HandshakeLimit; n++) begin
      @(posedge clk_i);
      saw_req = saw_req | flash_req_o;
      if (rdy_o) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      other_errs++;
      $display("the read of address 0x%h was never accepted", a);
    end else begin
      exp_mem[wr_idx] = exp;
      wr_idx = wr_idx + 8'd1;
      if (chk) begin
        check_flag("flash_req_o", saw_req, exp_req);
      end
    end
  endtask

  task automatic wait_idle(output bit ok);
    ok = 1'b0;
    for (int n = 0; n < IdleLimit; n++) begin
      @(posedge clk_i);
      if (idle_o) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      other_errs++;
      $display("the pipeline did not drain to idle in time");
    end
  endtask

  initial begin
    string       line;
    int          fd;
    int          n;
    logic [7:0]  cmd;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] f;
    bit          ok;
    bit          aborted;
    flag_errs  = 0;
    other_errs = 0;
    wr_idx     = '0;
    aborted    = 1'b0;
    ok         = 1'b1;
    rst_ni     = 1'b0;
    buf_en_i   = 1'b1;
    req_i      = 1'b0;
    prog_i     = 1'b0;
    addr_i     = '0;
    // upper half is the inverted address so every word differs
    for (int i = 0; i < 2**AddrW; i++) begin
      mem[addr_t'(i)] = {~addr_t'(i), addr_t'(i)};
    end

    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_flag("rdy_o", rdy_o, 1'b0);
    check_flag("data_valid_o", data_valid_o, 1'b0);
    check_flag("flash_req_o", flash_req_o, 1'b0);
    check_flag("idle_o", idle_o, 1'b1);

    fd = $fopen("test/flash_rd_testdata.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("cannot open test/flash_rd_testdata.txt");
      aborted = 1'b1;
    end
    while (!aborted && $fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h %h", cmd, a, d, f);
      if (cmd == "R") begin
        issue_read(addr_t'(a), d, n == 4, f[0], ok);
      end else begin
        // programs and enable changes only happen on an empty pipeline
        req_i <= 1'b0;
        wait_idle(ok);
        if (ok && cmd == "P") begin
          mem[addr_t'(a)] = d;
          addr_i <= addr_t'(a);
          prog_i <= 1'b1;
          @(posedge clk_i);
          prog_i <= 1'b0;
        end else if (ok && cmd == "E") begin
          buf_en_i <= a[0];
        end else if (ok) begin
          other_errs++;
          $display("unknown command in the test data");
        end
      end
      aborted = !ok;
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    req_i <= 1'b0;
    if (!aborted) begin
      wait_idle(ok);
    end
    if (rd_idx != wr_idx) begin
      other_errs++;
      $display("%0d accepted reads got no response", wr_idx - rd_idx);
    end
    $display("errors: data %0d, flag %0d, response %0d, other %0d",
             data_errs, flag_errs, resp_errs, other_errs);
    if (data_errs + flag_errs + resp_errs + other_errs == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule : flash_rd_tb

`default_nettype wire

// ==== test/flash_rd_props.sv ====
// concurrent assertions on the read buffers for one-hot selects, allocation and wipe targets
`default_nettype none

module flash_rd_props #(
  parameter int NumBuf = 4
) (
  input logic              clk_i,
  input logic              rst_ni,
  input logic [NumBuf-1:0] hit_sel_i,
  input logic [NumBuf-1:0] alloc_sel_i,
  input logic              alloc_en_i,
  input logic [NumBuf-1:0] buf_dep_i,
  input logic [NumBuf-1:0] buf_wip_i,
  input logic              wipe_en_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // an address lives in at most one buffer, so at most one can hit
  hit_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_sel_i)) else $error("hit_sel is not one-hot or zero");

  alloc_onehot_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(alloc_sel_i)) else $error("alloc_sel is not one-hot or zero");

  // a buffer that queued responses still read, or that waits on the flash, stays put
  alloc_free_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    alloc_en_i |-> ((alloc_sel_i & (buf_dep_i | buf_wip_i)) == '0))
    else $error("allocation hit a buffer that is still in use");

  // a program only comes on a drained pipeline, so no buffer may still wait on the flash
  wipe_target_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wipe_en_i |-> (buf_wip_i == '0))
    else $error("program arrived while a buffer waits on the flash");

endmodule : flash_rd_props

bind flash_rd_buffers flash_rd_props #(
  .NumBuf (NumBuf)
) i_props (
  .clk_i,
  .rst_ni,
  .hit_sel_i   (match),
  .alloc_sel_i (buf_if.alloc_sel),
  .alloc_en_i  (buf_if.alloc_en),
  .buf_dep_i   (buf_dep),
  .buf_wip_i   (buf_wip),
  .wipe_en_i   (buf_if.wipe_en)
);

`default_nettype wire

// ==== hdl/flash_rd_top.sv ====
// flash read pipeline top with the buffer-enable register and the issue, buffer and response stages
`default_nettype none

module flash_rd_top
  import flash_rd_pkg::*;
#(
  parameter int NumBuf   = NumBufDef,
  parameter int RspDepth = RspDepthDef
) (
  input  logic  clk_i,
  input  logic  rst_ni,

  // host side
  input  logic  buf_en_i,
  input  logic  req_i,
  input  logic  prog_i,
  input  addr_t addr_i,
  output logic  rdy_o,
  output logic  data_valid_o,
  output data_t data_o,
  output logic  idle_o,

  // flash primitive side
  output logic  flash_req_o,
  output addr_t flash_addr_o,
  input  logic  flash_ack_i,
  input  logic  flash_done_i,
  input  data_t flash_data_i
);

  logic buf_en_q;
  logic all_dep;

  flash_rd_buf_if   #(.NumBuf(NumBuf)) buf_if ();
  flash_rd_order_if #(.NumBuf(NumBuf)) ord_if ();

  // the enable only moves while nothing is queued
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      buf_en_q <= 1'b0;
    end else if (idle_o) begin
      buf_en_q <= buf_en_i;
    end
  end

  flash_rd_issue #(
    .NumBuf (NumBuf)
  ) u_issue (
    .clk_i,
    .rst_ni,
    .buf_en_q_i   (buf_en_q),
    .buf_en_i,
    .req_i,
    .prog_i,
    .addr_i,
    .rdy_o,
    .flash_req_o,
    .flash_addr_o,
    .flash_ack_i,
    .flash_done_i,
    .flash_data_i,
    .all_dep_i    (all_dep),
    .buf_if       (buf_if.issue),
    .ord_if       (ord_if.issue)
  );

  flash_rd_buffers #(
    .NumBuf   (NumBuf),
    .RspDepth (RspDepth)
  ) u_buffers (
    .clk_i,
    .rst_ni,
    .en_i      (buf_en_q),
    .buf_if    (buf_if.bufs),
    .ord_if    (ord_if.bufs),
    .all_dep_o (all_dep)
  );

  flash_rd_rsp #(
    .NumBuf   (NumBuf),
    .RspDepth (RspDepth)
  ) u_rsp (
    .clk_i,
    .rst_ni,
    .flash_done_i,
    .flash_data_i,
    .upd_sel_i    (buf_if.upd_sel),
    .data_valid_o,
    .data_o,
    .idle_o,
    .ord_if       (ord_if.rsp)
  );

endmodule : flash_rd_top

`default_nettype wire

// ==== hdl/flash_rd_rsp.sv ====
// response stage with the order FIFO, answering each request from a buffer or the flash
`default_nettype none

module flash_rd_rsp
  import flash_rd_pkg::*;
#(
  parameter int NumBuf   = 4,
  parameter int RspDepth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,

  // flash return and the buffer it fills
  input  logic              flash_done_i,
  input  data_t             flash_data_i,
  input  logic [NumBuf-1:0] upd_sel_i,

  // host response
  output logic              data_valid_o,
  output data_t             data_o,
  output logic              idle_o,

  flash_rd_order_if.rsp     ord_if
);

  localparam int PtrW = (RspDepth > 1) ? $clog2(RspDepth) : 1;
  localparam int CntW = $clog2(RspDepth + 1);

  ////////////////////////////////////////////////////////////
  // order FIFO
  ////////////////////////////////////////////////////////////

  logic [NumBuf-1:0] fifo_q [RspDepth];
  logic [PtrW-1:0]   wr_ptr_q;
  logic [PtrW-1:0]   rd_ptr_q;
  logic [CntW-1:0]   cnt_q;
  logic              empty;
  logic [NumBuf-1:0] head_sel;

  assign empty           = (cnt_q == '0);
  assign head_sel        = fifo_q[rd_ptr_q];
  assign ord_if.space_ok = (cnt_q != CntW'(RspDepth));
  // nothing queued means nothing in flight either
  assign idle_o          = empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (ord_if.push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(RspDepth - 1)) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (ord_if.pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(RspDepth - 1)) ? '0 : rd_ptr_q + PtrW'(1);
      end
      cnt_q <= cnt_q + CntW'(ord_if.push) - CntW'(ord_if.pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (ord_if.push) begin
      fifo_q[wr_ptr_q] <= ord_if.sel;
    end
  end

  ////////////////////////////////////////////////////////////
  // response select
  ////////////////////////////////////////////////////////////

  logic  buf_hit;
  logic  flash_hit;
  data_t buf_data;

  // a valid buffer answers at once, even while a later read is on the flash
  assign buf_hit = ~empty & |(head_sel & ord_if.rd_valid);

  // the flash answers the head that waits on the buffer being filled, or
  // any head at all when buffers were off
  assign flash_hit = ~empty & flash_done_i &
                     ((head_sel == upd_sel_i) | (head_sel == '0));

  always_comb begin
    buf_data = '0;
    for (int i = 0; i < NumBuf; i++) begin
      if (head_sel[i]) begin
        buf_data = ord_if.rd_data[i];
      end
    end
  end

  assign ord_if.pop     = buf_hit | flash_hit;
  assign ord_if.pop_sel = head_sel;

  assign data_valid_o = ord_if.pop;
  assign data_o       = buf_hit ? buf_data : flash_data_i;

endmodule : flash_rd_rsp

`default_nettype wire

// ==== hdl/flash_rd_buffers.sv ====
// read buffers with address match, allocation, flash update, program wipe and dependency counts
`default_nettype none

module flash_rd_buffers
  import flash_rd_pkg::*;
#(
  parameter int NumBuf   = 4,
  parameter int RspDepth = 4
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic en_i,

  flash_rd_buf_if.bufs   buf_if,
  flash_rd_order_if.bufs ord_if,

  // no buffer is free of queued responses
  output logic all_dep_o
);

  // a buffer can be named by every entry of the order FIFO
  localparam int CntW = $clog2(RspDepth + 1);

  // lowest set bit of a vector, as a one-hot vector
  function automatic logic [NumBuf-1:0] lowest_one(input logic [NumBuf-1:0] v);
    return v & (~v + NumBuf'(1));
  endfunction

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  buf_attr_e         attr_q    [NumBuf];
  addr_t             addr_q    [NumBuf];
  data_t             data_q    [NumBuf];
  logic [CntW-1:0]   dep_cnt_q [NumBuf];

  logic [NumBuf-1:0] buf_invalid;
  logic [NumBuf-1:0] buf_valid;
  logic [NumBuf-1:0] buf_wip;
  logic [NumBuf-1:0] buf_dep;
  logic [NumBuf-1:0] match;
  logic [NumBuf-1:0] wipe;
  logic [NumBuf-1:0] dep_inc;
  logic [NumBuf-1:0] dep_dec;

  for (genvar i = 0; i < NumBuf; i++) begin : gen_flags
    assign buf_invalid[i] = (attr_q[i] == BufInvalid);
    assign buf_valid[i]   = (attr_q[i] == BufValid);
    assign buf_wip[i]     = (attr_q[i] == BufWip);
    assign buf_dep[i]     = |dep_cnt_q[i];

    // a wip buffer also hits, its response waits for the flash
    assign match[i] = buf_if.lk_req & en_i & (buf_valid[i] | buf_wip[i]) &
                      (addr_q[i] == buf_if.lk_addr);

    // only a valid copy of the programmed word goes stale
    assign wipe[i] = buf_if.wipe_en & buf_valid[i] &
                     (addr_q[i] == buf_if.lk_addr);

    assign dep_inc[i] = ord_if.push & ord_if.sel[i];
    assign dep_dec[i] = ord_if.pop & ord_if.pop_sel[i];

    assign ord_if.rd_data[i] = data_q[i];
  end

  assign buf_if.hit     = |match;
  assign buf_if.hit_sel = match;
  assign ord_if.rd_valid = buf_valid;
  assign all_dep_o       = &buf_dep;

  ////////////////////////////////////////////////////////////
  // allocation
  ////////////////////////////////////////////////////////////

  // an empty buffer first, then the lowest valid one nobody waits on
  // wip buffers are never candidates
  assign buf_if.alloc_sel = |buf_invalid ? lowest_one(buf_invalid) :
                                           lowest_one(buf_valid & ~buf_dep);

  ////////////////////////////////////////////////////////////
  // state and dependency counts
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NumBuf; i++) begin
        attr_q[i]    <= BufInvalid;
        dep_cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumBuf; i++) begin
        // disabled buffers forget everything
        if (!en_i) begin
          attr_q[i] <= BufInvalid;
        end else if (buf_if.alloc_en && buf_if.alloc_sel[i]) begin
          attr_q[i] <= BufWip;
        end else if (buf_if.upd_en && buf_if.upd_sel[i]) begin
          attr_q[i] <= BufValid;
        end else if (wipe[i]) begin
          attr_q[i] <= BufInvalid;
        end
        // push and pop of the same buffer in one cycle cancel out
        dep_cnt_q[i] <= dep_cnt_q[i] + CntW'(dep_inc[i]) - CntW'(dep_dec[i]);
      end
    end
  end

  // address on allocation, data when the flash returns
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NumBuf; i++) begin
      if (buf_if.alloc_en && buf_if.alloc_sel[i]) begin
        addr_q[i] <= buf_if.lk_addr;
      end
      if (buf_if.upd_en && buf_if.upd_sel[i]) begin
        data_q[i] <= buf_if.upd_data;
      end
    end
  end

endmodule : flash_rd_buffers

`default_nettype wire

// ==== hdl/flash_rd_issue.sv ====
// issue stage that accepts host reads, looks up the buffers and runs one flash read at a time
`default_nettype none

module flash_rd_issue
  import flash_rd_pkg::*;
#(
  parameter int NumBuf = 4
) (
  input  logic  clk_i,
  input  logic  rst_ni,

  // sampled and live buffer enable
  input  logic  buf_en_q_i,
  input  logic  buf_en_i,

  // host side
  input  logic  req_i,
  input  logic  prog_i,
  input  addr_t addr_i,
  output logic  rdy_o,

  // flash primitive side
  output logic  flash_req_o,
  output addr_t flash_addr_o,
  input  logic  flash_ack_i,
  input  logic  flash_done_i,
  input  data_t flash_data_i,

  // every buffer still has queued responses
  input  logic  all_dep_i,

  flash_rd_buf_if.issue   buf_if,
  flash_rd_order_if.issue ord_if
);

  ////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////

  // the host address goes to the buffers unchanged, they gate the
  // match with their own enable
  assign buf_if.lk_addr = addr_i;
  assign buf_if.lk_req  = req_i;

  // while the enable is about to change nothing new may enter, the
  // top level samples it as soon as the pipeline drains
  logic en_match;
  assign en_match = (buf_en_q_i == buf_en_i);

  ////////////////////////////////////////////////////////////
  // outstanding flash read
  ////////////////////////////////////////////////////////////

  logic              rd_busy;
  logic              rd_start;
  logic              rd_done;
  logic [NumBuf-1:0] alloc_q;
  logic              flash_rdy;

  // done is only meaningful while our read is in flight
  assign rd_done   = rd_busy & flash_done_i;
  // the flash can take a new read in the cycle the current one ends
  assign flash_rdy = ~rd_busy | rd_done;

  ////////////////////////////////////////////////////////////
  // acceptance
  ////////////////////////////////////////////////////////////

  logic base_ok;
  logic alloc_ok;
  logic miss_ok;
  logic accept;

  // common conditions for hits and misses
  assign base_ok  = en_match & ~all_dep_i & ord_if.space_ok;

  // with buffers on, a miss needs somewhere to land
  assign alloc_ok = ~buf_en_q_i | (|buf_if.alloc_sel);
  assign miss_ok  = flash_rdy & alloc_ok;

  // a miss is held on the flash request until the primitive acks,
  // and the host sees rdy_o only in that ack cycle
  assign flash_req_o  = req_i & ~buf_if.hit & base_ok & miss_ok;
  assign flash_addr_o = addr_i;

  assign rdy_o = base_ok & (buf_if.hit | (miss_ok & flash_ack_i));

  assign accept   = req_i & rdy_o;
  assign rd_start = accept & ~buf_if.hit;

  // allocation happens in the acceptance cycle
  assign buf_if.alloc_en = rd_start & buf_en_q_i;

  // every accepted request leaves an order entry behind
  // Buffers off means a zero select, so the answer comes from the flash
  assign ord_if.push = accept;
  assign ord_if.sel  = buf_if.hit ? buf_if.hit_sel :
                       (buf_if.alloc_sel & {NumBuf{buf_en_q_i}});

  // remember which buffer the flash read is filling
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_busy <= 1'b0;
      alloc_q <= '0;
    end else if (rd_start) begin
      rd_busy <= 1'b1;
      alloc_q <= buf_if.alloc_sel & {NumBuf{buf_en_q_i}};
    end else if (rd_done) begin
      rd_busy <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // buffer update and program wipe
  ////////////////////////////////////////////////////////////

  // the saved select is zero when buffers were off at issue
  assign buf_if.upd_en   = rd_done;
  assign buf_if.upd_sel  = alloc_q;
  assign buf_if.upd_data = flash_data_i;

  // programs only arrive while idle, so lk_addr is the program address
  assign buf_if.wipe_en  = prog_i;

endmodule : flash_rd_issue

`default_nettype wire

// ==== hdl/flash_rd_order_if.sv ====
// response-order entries, the pop event and the buffer read port shared by three stages
`default_nettype none

interface flash_rd_order_if
  import flash_rd_pkg::*;
#(
  parameter int NumBuf = 4
) ();

  // push of an accepted request and the buffer that will answer it
  // a zero select means the answer comes straight from the flash
  logic                     push;
  logic [NumBuf-1:0]        sel;
  logic                     space_ok;

  // the head entry leaves the FIFO with this select
  logic                     pop;
  logic [NumBuf-1:0]        pop_sel;

  // buffer contents as seen by the response stage
  data_t [NumBuf-1:0]       rd_data;
  logic  [NumBuf-1:0]       rd_valid;

  modport issue (
    output push, sel,
    input  space_ok
  );

  modport rsp (
    input  push, sel, rd_data, rd_valid,
    output space_ok, pop, pop_sel
  );

  modport bufs (
    input  push, sel, pop, pop_sel,
    output rd_data, rd_valid
  );

endinterface : flash_rd_order_if

`default_nettype wire

// ==== hdl/flash_rd_buf_if.sv ====
// lookup, allocation, update and wipe channel between the issue stage and the read buffers
`default_nettype none

interface flash_rd_buf_if
  import flash_rd_pkg::*;
#(
  parameter int NumBuf = 4
) ();

  // lookup of the host address, valid while lk_req is high
  addr_t             lk_addr;
  logic              lk_req;

  // combinational answer from the buffers
  logic              hit;
  logic [NumBuf-1:0] hit_sel;
  // next buffer to allocate, zero when nothing can be replaced
  logic [NumBuf-1:0] alloc_sel;

  // one-cycle strobes from the issue stage
  logic              alloc_en;
  logic              upd_en;
  logic [NumBuf-1:0] upd_sel;
  data_t             upd_data;
  // program pulse, the word at lk_addr is no longer current
  logic              wipe_en;

  modport issue (
    output lk_addr, lk_req, alloc_en, upd_en, upd_sel, upd_data, wipe_en,
    input  hit, hit_sel, alloc_sel
  );

  modport bufs (
    input  lk_addr, lk_req, alloc_en, upd_en, upd_sel, upd_data, wipe_en,
    output hit, hit_sel, alloc_sel
  );

endinterface : flash_rd_buf_if

`default_nettype wire

// ==== hdl/flash_rd_pkg.sv ====
// flash read pipeline package with the word widths, default counts and buffer states
`default_nettype none

package flash_rd_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // a flash word address, one address per 32-bit word
  parameter int AddrW = 16;

  // the flash word itself, no integrity or ECC bits are kept
  parameter int DataW = 32;

  typedef logic [AddrW-1:0] addr_t;
  typedef logic [DataW-1:0] data_t;

  ////////////////////////////////////////////////////////////
  // counts
  ////////////////////////////////////////////////////////////

  // default number of read buffers
  parameter int NumBufDef = 4;

  // default depth of the response-order FIFO
  parameter int RspDepthDef = 4;

  ////////////////////////////////////////////////////////////
  // buffer state
  ////////////////////////////////////////////////////////////

  // invalid buffers hold nothing, a wip buffer waits on the flash
  // and a valid buffer holds the data of its address
  typedef enum logic [1:0] {
    BufInvalid = 2'b00,
    BufWip     = 2'b01,
    BufValid   = 2'b10
  } buf_attr_e;

endpackage : flash_rd_pkg

`default_nettype wire
